// ==== Makefile ====
# Verilator build and run of the m/2 filter bank testbench.

VERILATOR ?= verilator
TOP       ?= pfb_m2_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
EXE       ?= pfb_m2_sim
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the log must hold the pass line, otherwise the target fails.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(EXE)
	./$(BUILD_DIR)/$(EXE) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/pfb_ctrl_pkg.sv ====
//##################################################
// control types for the coefficient reload path.
//##################################################
`default_nettype none

package pfb_ctrl_pkg;

  // reload_drain drops words after the last slot.
  typedef enum logic [1:0] {
    reload_idle  = 2'd0,
    reload_load  = 2'd1,
    reload_drain = 2'd2
  } reload_state_t;

endpackage

`default_nettype wire

// ==== design/pfb_m2_filter.sv ====
//##################################################
// m/2 polyphase filter datapath.
// phase masking, m/2 delay, arm history, tap
// banks, mac pipeline and output fifo.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module pfb_m2_filter #(
  parameter int TAPS       = 4,
  parameter int PHASE_BITS = 4
) (
  input  logic                                 clk,
  input  logic                                 sync_reset,
  input  logic [PHASE_BITS:0]                  num_phases,
  input  logic [PHASE_BITS-1:0]                phase,
  input  logic                                 s_axis_tvalid,
  input  logic [2*pfb_types_pkg::sample_w-1:0] s_axis_tdata,
  input  logic                                 s_axis_tlast,
  output logic                                 s_axis_tready,
  input  logic                                 coef_we,
  input  logic [$clog2(TAPS)-1:0]              tap_sel,
  input  logic [PHASE_BITS-1:0]                coef_addr,
  input  logic [pfb_types_pkg::coef_w-1:0]     coef_data,
  output logic [PHASE_BITS-1:0]                phase_out,
  output logic                                 m_axis_tvalid,
  output logic [2*pfb_types_pkg::sample_w-1:0] m_axis_tdata,
  output logic                                 m_axis_tlast,
  input  logic                                 m_axis_tready
);

  localparam int SMP_W  = 2 * pfb_types_pkg::sample_w;
  localparam int CW     = pfb_types_pkg::coef_w;
  localparam int FIFO_W = SMP_W + 1 + PHASE_BITS;

  logic [PHASE_BITS-1:0] phase_m;
  logic                  take;
  logic [PHASE_BITS:0]   sweep_cnt;
  logic [PHASE_BITS-1:0] sweep_addr;
  logic                  sweeping;
  logic                  v1;
  logic                  last_d;
  logic [PHASE_BITS-1:0] phase_d;
  logic [SMP_W-1:0]      data_d;
  logic                  bot_half;
  logic                  delay_we;
  logic [PHASE_BITS-1:0] delay_addr;
  logic [SMP_W-1:0]      delay_din;
  logic [SMP_W-1:0]      delay_q;
  logic                  hist_we;
  logic [PHASE_BITS-1:0] hist_addr;
  logic [SMP_W-1:0]      hist_q [TAPS-1];
  logic [SMP_W-1:0]      arm_new [TAPS];
  logic [CW-1:0]         coef_q [TAPS];
  logic [TAPS*SMP_W-1:0] arm_vec;
  logic [TAPS*CW-1:0]    coef_vec;
  logic                  mac_valid;
  logic                  mac_last;
  logic [PHASE_BITS-1:0] mac_phase;
  logic [SMP_W-1:0]      mac_result;
  logic [FIFO_W-1:0]     fifo_out;
  logic                  almost_full;

  assign phase_m = phase & PHASE_BITS'(num_phases - 1'b1);

  // after reset, zeros are swept through every address of the delay and arm memories.
  assign sweeping      = ~sweep_cnt[PHASE_BITS];
  assign sweep_addr    = sweep_cnt[PHASE_BITS-1:0];
  assign s_axis_tready = ~almost_full & ~sweeping;
  assign take          = s_axis_tvalid & s_axis_tready;

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      sweep_cnt <= '0;
      v1        <= 1'b0;
    end else begin
      if (sweeping) begin
        sweep_cnt <= sweep_cnt + 1'b1;
      end
      v1 <= take;
    end
  end

  // stage 1 lines up with the memory read data.
  always_ff @(posedge clk) begin
    phase_d <= phase_m;
    data_d  <= s_axis_tdata;
    last_d  <= s_axis_tlast;
  end

  // the delay memory is written with every sample, so a read of the same
  // phase returns what that phase held one revolution back.
  assign delay_we   = sweeping | take;
  assign delay_addr = sweeping ? sweep_addr : phase_m;
  assign delay_din  = sweeping ? {SMP_W{1'b0}} : s_axis_tdata;

  sample_ram #(
    .DATA_W (SMP_W),
    .ADDR_W (PHASE_BITS)
  ) u_delay_ram (
    .clk     (clk),
    .we      (delay_we),
    .wr_addr (delay_addr),
    .wr_data (delay_din),
    .rd_addr (phase_m),
    .rd_data (delay_q)
  );

  // bottom half takes the delayed sample.
  assign bot_half = ({1'b0, phase_d} >= (num_phases >> 1));

  // newest tap comes straight from the arm input, older taps shift down one.
  always_comb begin
    arm_new[0] = bot_half ? delay_q : data_d;
    for (int j = 1; j < TAPS; j++) begin
      arm_new[j] = hist_q[j-1];
    end
  end

  assign hist_we   = sweeping | v1;
  assign hist_addr = sweeping ? sweep_addr : phase_d;

  for (genvar g = 0; g < TAPS - 1; g++) begin : g_hist
    sample_ram #(
      .DATA_W (SMP_W),
      .ADDR_W (PHASE_BITS)
    ) u_arm_ram (
      .clk     (clk),
      .we      (hist_we),
      .wr_addr (hist_addr),
      .wr_data (sweeping ? {SMP_W{1'b0}} : arm_new[g]),
      .rd_addr (phase_m),
      .rd_data (hist_q[g])
    );
  end

  for (genvar c = 0; c < TAPS; c++) begin : g_coef
    sample_ram #(
      .DATA_W (CW),
      .ADDR_W (PHASE_BITS)
    ) u_coef_ram (
      .clk     (clk),
      .we      (coef_we && (tap_sel == c)),
      .wr_addr (coef_addr),
      .wr_data (coef_data),
      .rd_addr (phase_m),
      .rd_data (coef_q[c])
    );

    assign arm_vec[c*SMP_W +: SMP_W] = arm_new[c];
    assign coef_vec[c*CW +: CW]      = coef_q[c];
  end

  pfb_mac_chain #(
    .TAPS       (TAPS),
    .PHASE_BITS (PHASE_BITS)
  ) u_mac (
    .clk        (clk),
    .sync_reset (sync_reset),
    .en         (v1),
    .arm_data   (arm_vec),
    .coef_data  (coef_vec),
    .last_in    (last_d),
    .phase_in   (phase_d),
    .valid_out  (mac_valid),
    .last_out   (mac_last),
    .phase_out  (mac_phase),
    .result     (mac_result)
  );

  pfb_out_fifo #(
    .DATA_W (FIFO_W)
  ) u_fifo (
    .clk         (clk),
    .sync_reset  (sync_reset),
    .wr_en       (mac_valid),
    .wr_data     ({mac_result, mac_last, mac_phase}),
    .almost_full (almost_full),
    .m_valid     (m_axis_tvalid),
    .m_data      (fifo_out),
    .m_ready     (m_axis_tready)
  );

  assign m_axis_tdata = fifo_out[FIFO_W-1 -: SMP_W];
  assign m_axis_tlast = fifo_out[PHASE_BITS];
  assign phase_out    = fifo_out[PHASE_BITS-1:0];

endmodule

`default_nettype wire

// ==== design/pfb_m2_top.sv ====
//##################################################
// m/2 polyphase filter bank, top level.
// reload fsm, reload counter and filter datapath.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module pfb_m2_top #(
  parameter int TAPS       = 4,
  parameter int PHASE_BITS = 4
) (
  input  logic                                 clk,
  input  logic                                 sync_reset,
  input  logic [PHASE_BITS:0]                  num_phases,
  input  logic [PHASE_BITS-1:0]                phase,
  input  logic                                 s_axis_tvalid,
  input  logic [2*pfb_types_pkg::sample_w-1:0] s_axis_tdata,
  input  logic                                 s_axis_tlast,
  output logic                                 s_axis_tready,
  input  logic                                 s_axis_reload_tvalid,
  input  logic [31:0]                          s_axis_reload_tdata,
  input  logic                                 s_axis_reload_tlast,
  output logic                                 s_axis_reload_tready,
  output logic [PHASE_BITS-1:0]                phase_out,
  output logic                                 m_axis_tvalid,
  output logic [2*pfb_types_pkg::sample_w-1:0] m_axis_tdata,
  output logic                                 m_axis_tlast,
  input  logic                                 m_axis_tready
);

  logic                             word_take;
  logic                             load_clear;
  logic                             load_done;
  logic                             coef_we;
  logic [pfb_types_pkg::coef_w-1:0] coef_data;
  logic [$clog2(TAPS)-1:0]          tap_sel;
  logic [PHASE_BITS-1:0]            coef_addr;

  tap_reload_fsm u_reload_fsm (
    .clk                  (clk),
    .sync_reset           (sync_reset),
    .s_axis_reload_tvalid (s_axis_reload_tvalid),
    .s_axis_reload_tdata  (s_axis_reload_tdata),
    .s_axis_reload_tlast  (s_axis_reload_tlast),
    .s_axis_reload_tready (s_axis_reload_tready),
    .load_done            (load_done),
    .word_take            (word_take),
    .load_clear           (load_clear),
    .coef_we              (coef_we),
    .coef_data            (coef_data)
  );

  tap_load_counter #(
    .TAPS       (TAPS),
    .PHASE_BITS (PHASE_BITS)
  ) u_load_cnt (
    .clk        (clk),
    .sync_reset (sync_reset),
    .num_phases (num_phases),
    .word_take  (word_take),
    .load_clear (load_clear),
    .load_done  (load_done),
    .tap_sel    (tap_sel),
    .coef_addr  (coef_addr)
  );

  pfb_m2_filter #(
    .TAPS       (TAPS),
    .PHASE_BITS (PHASE_BITS)
  ) u_filter (
    .clk           (clk),
    .sync_reset    (sync_reset),
    .num_phases    (num_phases),
    .phase         (phase),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .coef_we       (coef_we),
    .tap_sel       (tap_sel),
    .coef_addr     (coef_addr),
    .coef_data     (coef_data),
    .phase_out     (phase_out),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready)
  );

endmodule

`default_nettype wire

// ==== design/pfb_mac_chain.sv ====
//##################################################
// i/q multiply-accumulate pipeline, four stages.
// products, sum, rounding, saturation. valid,
// last and phase ride along.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module pfb_mac_chain #(
  parameter int TAPS       = 4,
  parameter int PHASE_BITS = 4
) (
  input  logic                                      clk,
  input  logic                                      sync_reset,
  input  logic                                      en,
  input  logic [TAPS*2*pfb_types_pkg::sample_w-1:0] arm_data,
  input  logic [TAPS*pfb_types_pkg::coef_w-1:0]     coef_data,
  input  logic                                      last_in,
  input  logic [PHASE_BITS-1:0]                     phase_in,
  output logic                                      valid_out,
  output logic                                      last_out,
  output logic [PHASE_BITS-1:0]                     phase_out,
  output logic [2*pfb_types_pkg::sample_w-1:0]      result
);

  localparam int SW   = pfb_types_pkg::sample_w;
  localparam int CW   = pfb_types_pkg::coef_w;
  localparam int AW   = pfb_types_pkg::acc_w;
  localparam int FRAC = pfb_types_pkg::coef_frac;

  localparam logic signed [AW-1:0] RND     = AW'(1) << (FRAC - 1);
  localparam logic signed [AW-1:0] SAT_MAX = AW'((1 << (SW - 1)) - 1);
  localparam logic signed [AW-1:0] SAT_MIN = -AW'(1 << (SW - 1));

  logic signed [SW+CW-1:0] prod_i [TAPS];
  logic signed [SW+CW-1:0] prod_q [TAPS];
  logic signed [AW-1:0]    tree_i, tree_q;
  logic signed [AW-1:0]    sum_i, sum_q;
  logic signed [AW-1:0]    rnd_i, rnd_q;
  logic [3:0]              vld;
  logic [3:0]              lst;
  logic [PHASE_BITS-1:0]   ph [4];

  function automatic logic [SW-1:0] sat(input logic signed [AW-1:0] v);
    if (v > SAT_MAX) begin
      return SW'(SAT_MAX);
    end else if (v < SAT_MIN) begin
      return SW'(SAT_MIN);
    end
    return v[SW-1:0];
  endfunction

  // i sits in the upper half of each packed sample.
  always_comb begin
    tree_i = '0;
    tree_q = '0;
    for (int j = 0; j < TAPS; j++) begin
      tree_i = tree_i + prod_i[j];
      tree_q = tree_q + prod_q[j];
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < TAPS; j++) begin
      prod_i[j] <= $signed(arm_data[j*2*SW+SW +: SW]) * $signed(coef_data[j*CW +: CW]);
      prod_q[j] <= $signed(arm_data[j*2*SW +: SW]) * $signed(coef_data[j*CW +: CW]);
    end
    sum_i  <= tree_i;
    sum_q  <= tree_q;
    rnd_i  <= (sum_i + RND) >>> FRAC;
    rnd_q  <= (sum_q + RND) >>> FRAC;
    result <= {sat(rnd_i), sat(rnd_q)};
    lst    <= {lst[2:0], last_in};
    ph[0]  <= phase_in;
    for (int s = 1; s < 4; s++) begin
      ph[s] <= ph[s-1];
    end
  end

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      vld <= '0;
    end else begin
      vld <= {vld[2:0], en};
    end
  end

  assign valid_out = vld[3];
  assign last_out  = lst[3];
  assign phase_out = ph[3];

endmodule

`default_nettype wire

// ==== design/pfb_out_fifo.sv ====
//##################################################
// output stream fifo, first-word fall-through.
// almost_full leaves room for samples in flight.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module pfb_out_fifo #(
  parameter int DATA_W = 37
) (
  input  logic              clk,
  input  logic              sync_reset,
  input  logic              wr_en,
  input  logic [DATA_W-1:0] wr_data,
  output logic              almost_full,
  output logic              m_valid,
  output logic [DATA_W-1:0] m_data,
  input  logic              m_ready
);

  localparam int DEPTH    = pfb_types_pkg::fifo_depth;
  localparam int AW       = $clog2(DEPTH);
  localparam int AF_LEVEL = DEPTH - pfb_types_pkg::pipe_lat - 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;
  logic              push;
  logic              pop;

  assign pop         = m_valid & m_ready;
  assign push        = wr_en & (count != (AW+1)'(DEPTH));
  assign m_valid     = (count != '0);
  assign m_data      = mem[rd_ptr];
  assign almost_full = (count >= (AW+1)'(AF_LEVEL));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/pfb_types_pkg.sv ====
//##################################################
// datapath widths for the m/2 filter bank.
// sample, coefficient and accumulator sizes,
// pipeline latency and output fifo depth.
//##################################################
`default_nettype none

package pfb_types_pkg;

  // width of each of the i and q parts.
  localparam int sample_w = 16;

  // signed coefficient width and its fraction bits.
  localparam int coef_w    = 16;
  localparam int coef_frac = 15;

  // room for taps * (sample * coef) without overflow.
  localparam int acc_w = 36;

  // cycles from sample acceptance to the fifo write.
  localparam int pipe_lat = 5;

  localparam int fifo_depth = 16;

endpackage

`default_nettype wire

// ==== design/sample_ram.sv ====
//##################################################
// simple dual-port ram, registered read.
// a read of the address being written returns the
// old contents.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module sample_ram #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 4
) (
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== design/tap_load_counter.sv ====
//##################################################
// reload word counter, tap-major order.
// phase steps first, wraps at num_phases-1, then
// the tap index steps.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module tap_load_counter #(
  parameter int TAPS       = 4,
  parameter int PHASE_BITS = 4
) (
  input  logic                      clk,
  input  logic                      sync_reset,
  input  logic [PHASE_BITS:0]       num_phases,
  input  logic                      word_take,
  input  logic                      load_clear,
  output logic                      load_done,
  output logic [$clog2(TAPS)-1:0]   tap_sel,
  output logic [PHASE_BITS-1:0]     coef_addr
);

  logic [PHASE_BITS-1:0]   phase_cnt;
  logic [PHASE_BITS-1:0]   phase_max;
  logic [$clog2(TAPS)-1:0] tap_cnt;
  logic                    at_wrap;
  logic                    at_last;

  assign phase_max = PHASE_BITS'(num_phases - 1'b1);
  assign at_wrap   = (phase_cnt == phase_max);
  assign at_last   = at_wrap && (tap_cnt == $clog2(TAPS)'(TAPS - 1));

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      phase_cnt <= '0;
      tap_cnt   <= '0;
      load_done <= 1'b0;
      tap_sel   <= '0;
      coef_addr <= '0;
    end else begin
      // hold the slot of the taken word for the write a cycle later.
      if (word_take) begin
        tap_sel   <= tap_cnt;
        coef_addr <= phase_cnt;
      end
      if (load_clear) begin
        phase_cnt <= '0;
        tap_cnt   <= '0;
        load_done <= 1'b0;
      end else if (word_take && !load_done) begin
        load_done <= at_last;
        if (at_wrap) begin
          phase_cnt <= '0;
          tap_cnt   <= tap_cnt + 1'b1;
        end else begin
          phase_cnt <= phase_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/tap_reload_fsm.sv ====
//##################################################
// coefficient reload stream state machine.
// accepts reload words, issues one write per kept
// word a cycle after acceptance, drops overflow.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module tap_reload_fsm (
  input  logic                              clk,
  input  logic                              sync_reset,
  input  logic                              s_axis_reload_tvalid,
  input  logic [31:0]                       s_axis_reload_tdata,
  input  logic                              s_axis_reload_tlast,
  output logic                              s_axis_reload_tready,
  input  logic                              load_done,
  output logic                              word_take,
  output logic                              load_clear,
  output logic                              coef_we,
  output logic [pfb_types_pkg::coef_w-1:0]  coef_data
);

  pfb_ctrl_pkg::reload_state_t state, state_nxt;
  logic rdy;
  logic keep;

  // ready in every state once out of reset.
  assign s_axis_reload_tready = rdy;
  assign word_take  = s_axis_reload_tvalid & rdy;
  assign load_clear = word_take & s_axis_reload_tlast;

  // a word taken after the last slot is filled is not written.
  assign keep = word_take & ~load_done & (state != pfb_ctrl_pkg::reload_drain);

  always_comb begin
    state_nxt = state;
    case (state)
      pfb_ctrl_pkg::reload_idle: begin
        if (word_take && !s_axis_reload_tlast) begin
          state_nxt = pfb_ctrl_pkg::reload_load;
        end
      end
      pfb_ctrl_pkg::reload_load: begin
        if (load_clear) begin
          state_nxt = pfb_ctrl_pkg::reload_idle;
        end else if (load_done) begin
          state_nxt = pfb_ctrl_pkg::reload_drain;
        end
      end
      pfb_ctrl_pkg::reload_drain: begin
        if (load_clear) begin
          state_nxt = pfb_ctrl_pkg::reload_idle;
        end
      end
      default: state_nxt = pfb_ctrl_pkg::reload_idle;
    endcase
  end

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      state   <= pfb_ctrl_pkg::reload_idle;
      rdy     <= 1'b0;
      coef_we <= 1'b0;
    end else begin
      state   <= state_nxt;
      rdy     <= 1'b1;
      coef_we <= keep;
    end
  end

  // only the low bits of each word carry the coefficient.
  always_ff @(posedge clk) begin
    if (word_take) begin
      coef_data <= s_axis_reload_tdata[pfb_types_pkg::coef_w-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== dv/pfb_m2_assert.sv ====
//##################################################
// stream handshake assertions, bound to the top.
// data holds while valid waits for ready.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module pfb_m2_assert (
  input logic        clk,
  input logic        sync_reset,
  input logic        s_axis_tvalid,
  input logic        s_axis_tready,
  input logic [31:0] s_axis_tdata,
  input logic        s_axis_reload_tvalid,
  input logic        s_axis_reload_tready,
  input logic [31:0] s_axis_reload_tdata,
  input logic        s_axis_reload_tlast,
  input logic        m_axis_tvalid,
  input logic        m_axis_tready,
  input logic [31:0] m_axis_tdata,
  input logic        m_axis_tlast
);

  // a stalled output keeps its word until taken.
  out_hold: assert property (@(posedge clk) disable iff (sync_reset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else $error("output word changed or vanished while stalled");

  in_hold: assert property (@(posedge clk) disable iff (sync_reset)
    s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis_tdata))
    else $error("sample withdrawn before it was accepted");

  // a reload word offered must stay until the fsm takes it.
  reload_hold: assert property (@(posedge clk) disable iff (sync_reset)
    s_axis_reload_tvalid && !s_axis_reload_tready |=>
      s_axis_reload_tvalid && $stable(s_axis_reload_tdata) && $stable(s_axis_reload_tlast))
    else $error("reload word dropped before ready");

endmodule

bind pfb_m2_top pfb_m2_assert u_stream_assert (
  .clk                  (clk),
  .sync_reset           (sync_reset),
  .s_axis_tvalid        (s_axis_tvalid),
  .s_axis_tready        (s_axis_tready),
  .s_axis_tdata         (s_axis_tdata),
  .s_axis_reload_tvalid (s_axis_reload_tvalid),
  .s_axis_reload_tready (s_axis_reload_tready),
  .s_axis_reload_tdata  (s_axis_reload_tdata),
  .s_axis_reload_tlast  (s_axis_reload_tlast),
  .m_axis_tvalid        (m_axis_tvalid),
  .m_axis_tready        (m_axis_tready),
  .m_axis_tdata         (m_axis_tdata),
  .m_axis_tlast         (m_axis_tlast)
);

`default_nettype wire

// ==== dv/pfb_m2_tb.sv ====
//##################################################
// testbench for the m/2 polyphase filter bank.
// reload and sample stimulus, reference model,
// output compare and per-test reporting.
//##################################################
`timescale 1ns/1ns
`default_nettype none

module pfb_m2_tb;

  localparam int TAPS       = 4;
  localparam int PHASE_BITS = 4;
  localparam int MAX_PH     = 1 << PHASE_BITS;
  localparam int OUT_W      = 32 + 1 + PHASE_BITS;

  // samples and reload words summed over every test below.
  localparam int TOTAL_SAMPLES = 24 + 96 + 24 + 32 + 64 + 16;
  localparam int TOTAL_WORDS   = 32 + 64 + 16 + 37;
  localparam int CYCLE_LIMIT   = (TOTAL_SAMPLES + TOTAL_WORDS) * 4 + 200;

  logic                  clk = 1'b0;
  logic                  sync_reset;
  logic [PHASE_BITS:0]   num_phases;
  logic [PHASE_BITS-1:0] phase;
  logic                  s_axis_tvalid;
  logic [31:0]           s_axis_tdata;
  logic                  s_axis_tlast;
  logic                  s_axis_tready;
  logic                  s_axis_reload_tvalid;
  logic [31:0]           s_axis_reload_tdata;
  logic                  s_axis_reload_tlast;
  logic                  s_axis_reload_tready;
  logic [PHASE_BITS-1:0] phase_out;
  logic                  m_axis_tvalid;
  logic [31:0]           m_axis_tdata;
  logic                  m_axis_tlast;
  logic                  m_axis_tready = 1'b1;

  // reference model state, indexed by masked phase.
  logic signed [15:0] coef_m [TAPS][MAX_PH];
  logic [31:0]        arm_m [TAPS][MAX_PH];
  logic [31:0]        delay_m [MAX_PH];

  logic [OUT_W-1:0] exp_q [$];
  logic [OUT_W-1:0] exp_word;
  string            test_name = "reset";
  integer           seed = 3;
  integer           bp_seed = 3;
  logic             bp_on = 1'b0;
  logic             reported = 1'b0;
  int               errors = 0;
  int               checks = 0;
  int               start_errs;
  int               start_checks;
  int               cycles = 0;

  pfb_m2_top #(
    .TAPS       (TAPS),
    .PHASE_BITS (PHASE_BITS)
  ) dut (
    .clk                  (clk),
    .sync_reset           (sync_reset),
    .num_phases           (num_phases),
    .phase                (phase),
    .s_axis_tvalid        (s_axis_tvalid),
    .s_axis_tdata         (s_axis_tdata),
    .s_axis_tlast         (s_axis_tlast),
    .s_axis_tready        (s_axis_tready),
    .s_axis_reload_tvalid (s_axis_reload_tvalid),
    .s_axis_reload_tdata  (s_axis_reload_tdata),
    .s_axis_reload_tlast  (s_axis_reload_tlast),
    .s_axis_reload_tready (s_axis_reload_tready),
    .phase_out            (phase_out),
    .m_axis_tvalid        (m_axis_tvalid),
    .m_axis_tdata         (m_axis_tdata),
    .m_axis_tlast         (m_axis_tlast),
    .m_axis_tready        (m_axis_tready)
  );

  always #4 clk = ~clk;

  function automatic logic [15:0] clip16(input longint v);
    if (v > 32767) begin
      return 16'h7fff;
    end else if (v < -32768) begin
      return 16'h8000;
    end
    return v[15:0];
  endfunction

  // top half takes the new sample, bottom half the one from a revolution back.
  function automatic logic [31:0] model_output(input int k, input int m, input logic [31:0] s);
    logic [31:0] arm_in;
    longint      acc_i;
    longint      acc_q;
    longint      half;
    arm_in = (k < m / 2) ? s : delay_m[k];
    delay_m[k] = s;
    for (int j = TAPS - 1; j > 0; j--) begin
      arm_m[j][k] = arm_m[j-1][k];
    end
    arm_m[0][k] = arm_in;
    acc_i = 0;
    acc_q = 0;
    for (int j = 0; j < TAPS; j++) begin
      acc_i += longint'(coef_m[j][k]) * longint'($signed(arm_m[j][k][31:16]));
      acc_q += longint'(coef_m[j][k]) * longint'($signed(arm_m[j][k][15:0]));
    end
    half  = longint'(1) << (pfb_types_pkg::coef_frac - 1);
    acc_i = (acc_i + half) >>> pfb_types_pkg::coef_frac;
    acc_q = (acc_q + half) >>> pfb_types_pkg::coef_frac;
    return {clip16(acc_i), clip16(acc_q)};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // outputs are compared in order as they leave the fifo.
  always @(posedge clk) begin
    if (m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("test %s: output appeared with no sample outstanding", test_name);
      end else begin
        exp_word = exp_q.pop_front();
        check_value(test_name, 64'(exp_word), 64'({m_axis_tdata, m_axis_tlast, phase_out}));
      end
    end
  end

  // output back-pressure, random while enabled.
  always @(negedge clk) begin
    m_axis_tready = bp_on ? (($random(bp_seed) & 1) != 0) : 1'b1;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d outputs never seen", cycles, exp_q.size());
      reported = 1'b1;
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic send_word(input logic [31:0] data, input logic last);
    logic ok;
    s_axis_reload_tvalid = 1'b1;
    s_axis_reload_tdata  = data;
    s_axis_reload_tlast  = last;
    ok = 1'b0;
    while (!ok) begin
      ok = s_axis_reload_tready;
      @(negedge clk);
    end
    s_axis_reload_tvalid = 1'b0;
  endtask

  // tap-major reload, words past taps*m are sent but must be dropped.
  task automatic reload_coefs(input int m, input int extra, input bit unit_tap0);
    logic [31:0] w;
    int          n;
    n = TAPS * m + extra;
    num_phases = (PHASE_BITS + 1)'(m);
    for (int i = 0; i < n; i++) begin
      w = $random(seed);
      if (unit_tap0) begin
        w[15:0] = (i < m) ? 16'h7fff : 16'h0000;
      end
      if (i < TAPS * m) begin
        coef_m[i / m][i % m] = w[15:0];
      end
      send_word(w, i == n - 1);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic send_sample(input logic [PHASE_BITS-1:0] ph, input logic [31:0] data,
                             input logic last, input logic direct,
                             input logic [31:0] direct_val);
    logic                  ok;
    logic [31:0]           y;
    logic [PHASE_BITS-1:0] ph_m;
    s_axis_tvalid = 1'b1;
    phase         = ph;
    s_axis_tdata  = data;
    s_axis_tlast  = last;
    ok = 1'b0;
    while (!ok) begin
      ok = s_axis_tready;
      @(negedge clk);
    end
    s_axis_tvalid = 1'b0;
    ph_m = PHASE_BITS'(int'(ph) % int'(num_phases));
    y = model_output(int'(ph_m), int'(num_phases), data);
    exp_q.push_back({(direct ? direct_val : y), last, ph_m});
  endtask

  // narrow samples keep a unit tap exact, so the output is the arm input itself.
  task automatic run_samples(input int m, input int revs, input bit narrow, input bit junk_phase);
    logic [31:0]           d;
    logic [31:0]           direct_val;
    logic [31:0]           prev [MAX_PH];
    logic [PHASE_BITS-1:0] ph;
    logic [PHASE_BITS-1:0] junk;
    logic                  last;
    for (int k = 0; k < MAX_PH; k++) begin
      prev[k] = '0;
    end
    for (int r = 0; r < revs; r++) begin
      for (int k = 0; k < m; k++) begin
        d = $random(seed);
        if (narrow) begin
          d = {{4{d[27]}}, d[27:16], {4{d[11]}}, d[11:0]};
        end
        ph = PHASE_BITS'(k);
        if (junk_phase) begin
          junk = $random(seed);
          ph = ph | (junk & ~PHASE_BITS'(m - 1));
        end
        last = $random(seed);
        direct_val = (k < m / 2) ? d : prev[k];
        prev[k] = d;
        send_sample(ph, d, last, narrow, direct_val);
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    start_checks = checks;
    start_errs   = errors;
  endtask

  task automatic end_test();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("test %s: %0d outputs checked, %0d mismatches", test_name,
             checks - start_checks, errors - start_errs);
  endtask

  initial begin
    for (int k = 0; k < MAX_PH; k++) begin
      delay_m[k] = '0;
      for (int j = 0; j < TAPS; j++) begin
        arm_m[j][k]  = '0;
        coef_m[j][k] = '0;
      end
    end
    sync_reset           = 1'b1;
    num_phases           = (PHASE_BITS + 1)'(8);
    phase                = '0;
    s_axis_tvalid        = 1'b0;
    s_axis_tdata         = '0;
    s_axis_tlast         = 1'b0;
    s_axis_reload_tvalid = 1'b0;
    s_axis_reload_tdata  = '0;
    s_axis_reload_tlast  = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    sync_reset = 1'b0;

    begin_test("impulse");
    reload_coefs(8, 0, 1'b1);
    run_samples(8, 3, 1'b1, 1'b0);
    end_test();

    begin_test("random");
    reload_coefs(16, 0, 1'b0);
    run_samples(16, 6, 1'b0, 1'b0);
    end_test();

    begin_test("phase_mask");
    reload_coefs(4, 0, 1'b0);
    run_samples(4, 6, 1'b0, 1'b1);
    end_test();

    // no reload here, the banks keep what the last two loads wrote.
    begin_test("tlast");
    num_phases = (PHASE_BITS + 1)'(16);
    run_samples(16, 2, 1'b0, 1'b0);
    end_test();

    begin_test("backpressure");
    bp_on = 1'b1;
    run_samples(16, 4, 1'b0, 1'b0);
    end_test();
    bp_on = 1'b0;

    begin_test("long_reload");
    reload_coefs(8, 5, 1'b0);
    run_samples(8, 2, 1'b0, 1'b0);
    end_test();

    $display("all tests: %0d outputs checked, %0d errors", checks, errors);
    reported = 1'b1;
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  final begin
    if (!reported) begin
      $display("Finished with errors");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/pfb_types_pkg.sv
design/pfb_ctrl_pkg.sv
design/sample_ram.sv
design/tap_reload_fsm.sv
design/tap_load_counter.sv
design/pfb_mac_chain.sv
design/pfb_out_fifo.sv
design/pfb_m2_filter.sv
design/pfb_m2_top.sv
dv/pfb_m2_assert.sv
dv/pfb_m2_tb.sv
